//--- hw/cpuPkg.sv
package cpuPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int dataWidth  = 16; // Data and address width
  localparam int regCount   = 16; // Number of registers
  localparam int regIdWidth = 4;  // Register ID width

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////
  // Instruction opcode, bits 15:12 of the word
  typedef enum logic [3:0] {
    opAdd, opSub, opXor, opRed, opSll, opSra, opRor, opPaddsb,
    opLw, opSw, opLlb, opLhb, opB, opBr, opPcs, opHlt
  } opcode_e;

  // ALU operation, same code as the opcode where the ALU does the real work
  typedef enum logic [3:0] {
    aluAdd    = 4'd0,
    aluSub    = 4'd1,
    aluXor    = 4'd2,
    aluRed    = 4'd3,
    aluSll    = 4'd4,
    aluSra    = 4'd5,
    aluRor    = 4'd6,
    aluPaddsb = 4'd7,
    aluLlb    = 4'd10,
    aluLhb    = 4'd11
  } aluOp_e;

  // Branch condition, bits 11:9 of a B or BR word
  typedef enum logic [2:0] {
    condNe, condEq, condGt, condLt, condGte, condLte, condOvf, condUncond
  } cond_e;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic zf; // Zero
    logic vf; // Overflow
    logic nf; // Negative
  } flags_t;

  // Control unit output
  typedef struct packed {
    logic   aluSrc;    // Immediate on ALU input 2
    logic   memToReg;  // Write back the memory data
    logic   regWrite;  // Instruction writes rd
    logic   regSrc;    // Read rd on port 1 (LLB/LHB)
    logic   memEnable; // Data memory access
    logic   memWrite;  // Store
    logic   isBranch;  // B or BR
    logic   hlt;
    logic   pcs;
    aluOp_e aluOp;
    logic   zEn;       // Z flag update
    logic   nvEn;      // N and V flag update
  } ctrl_t;

  typedef struct packed {
    logic [regIdWidth-1:0] srcReg1;
    logic [regIdWidth-1:0] srcReg2;
    logic [dataWidth-1:0]  aluIn1;
    logic [dataWidth-1:0]  aluIn2;
    aluOp_e                aluOp;
    logic                  zEn;
    logic                  nvEn;
  } exBundle_t;

  typedef struct packed {
    logic [dataWidth-1:0] memWriteData;
    logic                 memEnable;
    logic                 memWrite;
  } memBundle_t;

  typedef struct packed {
    logic [regIdWidth-1:0] rd;
    logic                  regWrite;
    logic                  memToReg;
    logic                  hlt;
    logic                  pcs;
  } wbBundle_t;

  // Write-back port into the register file
  typedef struct packed {
    logic [regIdWidth-1:0] rd;
    logic                  en;
    logic [dataWidth-1:0]  data;
  } regWrite_t;

endpackage

//--- hw/controlUnit.sv
module controlUnit import cpuPkg::*; (
  input  logic    clk,    // Assertion sampling only
  input  logic    rstN,
  input  opcode_e opcode,
  output ctrl_t   ctrl
);

  ////////////////////////////////////////////////////////////////////////////
  // Control table
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    ctrl = '0;

    // Everything writes rd except stores, branches and halt
    ctrl.regWrite  = !(opcode inside {opSw, opB, opBr, opHlt});
    ctrl.aluSrc    = opcode inside {opSll, opSra, opRor, opLlb, opLhb}; // Immediate forms
    ctrl.regSrc    = opcode inside {opLlb, opLhb}; // Byte loads modify rd in place

    // Memory stage
    ctrl.memEnable = opcode inside {opLw, opSw};
    ctrl.memWrite  = (opcode == opSw);
    ctrl.memToReg  = (opcode == opLw);

    // Flag updates
    ctrl.zEn       = opcode inside {opAdd, opSub, opXor, opSll, opSra, opRor};
    ctrl.nvEn      = opcode inside {opAdd, opSub};

    // Flow control
    ctrl.isBranch  = opcode inside {opB, opBr};
    ctrl.hlt       = (opcode == opHlt);
    ctrl.pcs       = (opcode == opPcs);

    // ALU operation
    unique case (opcode)
      opAdd:    ctrl.aluOp = aluAdd;
      opSub:    ctrl.aluOp = aluSub;
      opXor:    ctrl.aluOp = aluXor;
      opRed:    ctrl.aluOp = aluRed;
      opSll:    ctrl.aluOp = aluSll;
      opSra:    ctrl.aluOp = aluSra;
      opRor:    ctrl.aluOp = aluRor;
      opPaddsb: ctrl.aluOp = aluPaddsb;
      opLlb:    ctrl.aluOp = aluLlb;
      opLhb:    ctrl.aluOp = aluLhb;
      // Address add for LW/SW, pass-through add for the rest
      default:  ctrl.aluOp = aluAdd;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////
  // A store never also writes a register back
  memWriteNoRegWrite : assert property (
    @(posedge clk) disable iff (!rstN)
    ctrl.memWrite |-> !ctrl.regWrite
  ) else $error("controlUnit: memWrite with regWrite, opcode %0d", opcode);

  // Branches never touch data memory
  branchNoMem : assert property (
    @(posedge clk) disable iff (!rstN)
    ctrl.isBranch |-> !ctrl.memEnable
  ) else $error("controlUnit: isBranch with memEnable, opcode %0d", opcode);

endmodule

//--- hw/registerFile.sv
module registerFile import cpuPkg::*; (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [regIdWidth-1:0] readId1,
  input  logic [regIdWidth-1:0] readId2,
  input  regWrite_t             wbPort,   // From write-back
  output logic [dataWidth-1:0]  readData1,
  output logic [dataWidth-1:0]  readData2
);

  logic [dataWidth-1:0] regs [regCount]; // Register array
  logic                 wrLive;          // Write that actually lands this cycle

  assign wrLive = wbPort.en && (wbPort.rd != '0); // R0 is hardwired

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (wrLive) begin
      regs[wbPort.rd] <= wbPort.data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read ports with write-through
  ////////////////////////////////////////////////////////////////////////////
  // Same-cycle write wins over the stored value
  function automatic logic [dataWidth-1:0] readPort(input logic [regIdWidth-1:0] id);
    if (wrLive && (wbPort.rd == id)) begin
      return wbPort.data;
    end
    return regs[id];
  endfunction

  always_comb begin
    readData1 = readPort(readId1);
    readData2 = readPort(readId2);
  end

  // R0 reads zero on both ports whatever the write port does
  r0ReadsZero : assert property (
    @(posedge clk) disable iff (!rstN)
    ((readId1 == '0) |-> (readData1 == '0)) and ((readId2 == '0) |-> (readData2 == '0))
  ) else $error("registerFile: R0 read back nonzero");

endmodule

//--- hw/branchControl.sv
module branchControl import cpuPkg::*; (
  input  logic                 isBranch,     // B or BR in decode
  input  logic                 isBr,         // Low opcode bit, register target
  input  cond_e                cond,
  input  logic [8:0]           branchImm,    // Word offset
  input  flags_t               flags,
  input  logic [dataWidth-1:0] pcNext,
  input  logic [dataWidth-1:0] rsData,       // Read port 1
  output logic                 taken,
  output logic [dataWidth-1:0] branchTarget
);

  logic                 condMet;   // Condition holds on current flags
  logic [dataWidth-1:0] byteOff;   // Sign-extended offset in bytes

  ////////////////////////////////////////////////////////////////////////////
  // Condition evaluation
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    unique case (cond)
      condNe:     condMet = !flags.zf;
      condEq:     condMet = flags.zf;
      condGt:     condMet = !flags.zf && !flags.nf;
      condLt:     condMet = flags.nf;
      condGte:    condMet = flags.zf || !flags.nf;
      condLte:    condMet = flags.nf || flags.zf;
      condOvf:    condMet = flags.vf;
      default:    condMet = 1'b1; // Unconditional
    endcase
  end

  assign taken = isBranch && condMet;

  // Target, B is PC-relative and BR jumps to the register
  assign byteOff      = {{(dataWidth - 10){branchImm[8]}}, branchImm, 1'b0};
  assign branchTarget = isBr ? rsData : pcNext + byteOff;

  // No redirect from anything but a branch
  takenNeedsBranch : assert final (!taken || isBranch)
    else $error("branchControl: taken without isBranch");

endmodule

//--- hw/operandSelect.sv
module operandSelect import cpuPkg::*; (
  input  ctrl_t                 ctrl,
  input  logic [regIdWidth-1:0] rd,
  input  logic [regIdWidth-1:0] rs,
  input  logic [regIdWidth-1:0] rt,
  input  logic [7:0]            lowByte,   // instr[7:0]
  output logic [regIdWidth-1:0] readId1,
  output logic [regIdWidth-1:0] readId2,
  input  logic [dataWidth-1:0]  readData1,
  input  logic [dataWidth-1:0]  readData2,
  output exBundle_t             exBundle,
  output memBundle_t            memBundle,
  output wbBundle_t             wbBundle
);

  logic [dataWidth-1:0] aluIn2;    // Second ALU operand
  logic [dataWidth-1:0] nibbleSx;  // Memory offset, signed
  logic [dataWidth-1:0] immZx;     // Shift amount or byte immediate

  ////////////////////////////////////////////////////////////////////////////
  // Register selection
  ////////////////////////////////////////////////////////////////////////////
  assign readId1 = ctrl.regSrc   ? rd : rs; // LLB/LHB merge into rd
  assign readId2 = ctrl.memWrite ? rd : rt; // SW stores rd

  ////////////////////////////////////////////////////////////////////////////
  // Second operand
  ////////////////////////////////////////////////////////////////////////////
  assign nibbleSx = {{(dataWidth - 4){lowByte[3]}}, lowByte[3:0]};
  assign immZx    = ctrl.regSrc ? {{(dataWidth - 8){1'b0}}, lowByte}
                                : {{(dataWidth - 4){1'b0}}, lowByte[3:0]};

  always_comb begin
    if (ctrl.memEnable) begin
      aluIn2 = nibbleSx;   // LW/SW address offset
    end else if (ctrl.aluSrc) begin
      aluIn2 = immZx;
    end else begin
      aluIn2 = readData2;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage bundles
  ////////////////////////////////////////////////////////////////////////////
  assign exBundle = '{srcReg1: readId1, srcReg2: readId2,
                      aluIn1: readData1, aluIn2: aluIn2,
                      aluOp: ctrl.aluOp, zEn: ctrl.zEn, nvEn: ctrl.nvEn};

  assign memBundle = '{memWriteData: readData2,
                       memEnable: ctrl.memEnable, memWrite: ctrl.memWrite};

  assign wbBundle = '{rd: rd, regWrite: ctrl.regWrite, memToReg: ctrl.memToReg,
                      hlt: ctrl.hlt, pcs: ctrl.pcs};

endmodule

//--- hw/decodeStage.sv
module decodeStage import cpuPkg::*; (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [dataWidth-1:0] instr,
  input  logic [dataWidth-1:0] pcNext,
  input  flags_t               flags,        // From execute
  input  regWrite_t            wbPort,       // From write-back
  output exBundle_t            exBundle,
  output memBundle_t           memBundle,
  output wbBundle_t            wbBundle,
  output logic                 isBranch,
  output logic [dataWidth-1:0] branchTarget,
  output logic                 taken
);

  ctrl_t                 ctrl;
  logic [regIdWidth-1:0] readId1, readId2;
  logic [dataWidth-1:0]  readData1, readData2;

  ////////////////////////////////////////////////////////////////////////////
  // Field split and block wiring
  ////////////////////////////////////////////////////////////////////////////
  controlUnit uCtrl (.clk, .rstN, .opcode(opcode_e'(instr[15:12])), .ctrl);

  registerFile uRegs (
    .clk, .rstN,
    .readId1, .readId2,
    .wbPort,
    .readData1, .readData2
  );

  operandSelect uOps (
    .ctrl,
    .rd(instr[11:8]), .rs(instr[7:4]), .rt(instr[3:0]), // Register fields
    .lowByte(instr[7:0]),
    .readId1, .readId2, .readData1, .readData2,
    .exBundle, .memBundle, .wbBundle
  );

  branchControl uBranch (
    .isBranch(ctrl.isBranch),
    .isBr(instr[12]),                 // B=1100, BR=1101
    .cond(cond_e'(instr[11:9])),
    .branchImm(instr[8:0]),
    .flags, .pcNext,
    .rsData(readData1),
    .taken, .branchTarget
  );

  assign isBranch = ctrl.isBranch;

endmodule

//--- test/decodeTasks.svh
`ifndef DECODE_TASKS_SVH
`define DECODE_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// Drivers and checks
////////////////////////////////////////////////////////////////////////////
task automatic failRun(input string why);
  $display("%s", why);
  $display("Testbench failed");
  $fatal(1, "Stopping at first error");
endtask

task automatic checkValue(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
  if (actual !== expected) begin
    failRun($sformatf("ERROR at %0t: %s expected %0h, got %0h",
                      $time, name, expected, actual));
  end
endtask

// Inputs change on the rising edge, outputs read at the falling edge
task automatic driveCycle(input logic [15:0] word, input logic wrEn,
                          input logic [3:0] wrId, input logic [15:0] wrData);
  @(posedge clk);
  instr       <= word;
  wbPort.rd   <= wrId;
  wbPort.en   <= wrEn;  // Write lands on the next rising edge
  wbPort.data <= wrData;
  @(negedge clk);
endtask

task automatic driveBranch(input logic [15:0] word, input logic [2:0] fl,
                           input logic [15:0] pc);
  @(posedge clk);
  instr  <= word;
  flags  <= flags_t'(fl); // {zf, vf, nf}
  pcNext <= pc;
  wbPort <= '0;
  @(negedge clk);
endtask

////////////////////////////////////////////////////////////////////////////
// Reference decode
////////////////////////////////////////////////////////////////////////////
// {aluOp, zEn, nvEn, memEnable, memWrite, regWrite, memToReg, hlt, pcs, isBranch}
function automatic logic [12:0] expectedControl(input logic [3:0] op);
  logic [3:0] aluOp;
  logic       regWrite;
  aluOp    = (op <= 4'd7 || op == 4'd10 || op == 4'd11) ? op : 4'd0; // Else ADD
  regWrite = !(op == 4'd9 || op == 4'd12 || op == 4'd13 || op == 4'd15);
  return {aluOp,
          (op <= 4'd2) || (op >= 4'd4 && op <= 4'd6), // zEn
          (op <= 4'd1),                               // nvEn
          (op == 4'd8 || op == 4'd9),
          (op == 4'd9),
          regWrite,
          (op == 4'd8),
          (op == 4'd15),
          (op == 4'd14),
          (op == 4'd12 || op == 4'd13)};
endfunction

function automatic logic condHolds(input logic [2:0] cond, input logic [2:0] zvn);
  logic z;
  logic v;
  logic n;
  z = zvn[2];
  v = zvn[1];
  n = zvn[0];
  case (cond)
    3'd0:    return !z;         // NE
    3'd1:    return z;          // EQ
    3'd2:    return !z && !n;   // GT
    3'd3:    return n;          // LT
    3'd4:    return z || !n;    // GTE
    3'd5:    return n || z;     // LTE
    3'd6:    return v;          // OVF
    default: return 1'b1;
  endcase
endfunction

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////
task automatic regWriteRead();
  logic [3:0]  rs;
  logic [3:0]  rt;
  logic [15:0] data;
  for (int i = 1; i < regCount; i++) begin
    data = 16'($urandom);
    driveCycle(16'h0000, 1'b1, 4'(i), data);
    regModel[i] = data;
  end
  for (int n = 0; n < 40; n++) begin
    rs = 4'($urandom);
    rt = 4'($urandom);
    driveCycle({4'd0, 4'($urandom), rs, rt}, 1'b0, 4'd0, 16'd0); // ADD
    checkValue("srcReg1", 32'(rs), 32'(exBundle.srcReg1));
    checkValue("srcReg2", 32'(rt), 32'(exBundle.srcReg2));
    checkValue("aluIn1", 32'(regModel[rs]), 32'(exBundle.aluIn1));
    checkValue("aluIn2", 32'(regModel[rt]), 32'(exBundle.aluIn2));
  end
endtask

task automatic r0AndBypass();
  logic [3:0]  id;
  logic [15:0] data;
  driveCycle(16'h0000, 1'b1, 4'd0, 16'hffff); // Write R0 while reading it
  checkValue("aluIn1 (R0 during write)", 32'd0, 32'(exBundle.aluIn1));
  driveCycle(16'h0000, 1'b0, 4'd0, 16'd0);
  checkValue("aluIn2 (R0 after write)", 32'd0, 32'(exBundle.aluIn2));
  for (int n = 0; n < 8; n++) begin
    id   = 4'($urandom_range(15, 1));
    data = 16'($urandom);
    driveCycle({4'd1, 4'd0, id, id}, 1'b1, id, data); // SUB reads Rn on both ports
    checkValue("aluIn1 (bypass)", 32'(data), 32'(exBundle.aluIn1));
    checkValue("aluIn2 (bypass)", 32'(data), 32'(exBundle.aluIn2));
    regModel[id] = data;
  end
  driveCycle({4'd2, 4'd0, id, 4'd0}, 1'b0, 4'd0, 16'd0);
  checkValue("aluIn1 (stored)", 32'(regModel[id]), 32'(exBundle.aluIn1));
endtask

task automatic immediateForms();
  logic [3:0]  op;
  logic [15:0] word;
  logic [3:0]  id1;
  logic [3:0]  id2;
  logic [15:0] imm;
  for (int n = 0; n < 10; n++) begin
    for (int k = 4; k < 12; k++) begin
      if (k != 7) begin // PADDSB has no immediate
        op   = 4'(k);
        word = {op, 12'($urandom)};
        id1  = (op >= 4'd10) ? word[11:8] : word[7:4]; // LLB/LHB read rd
        id2  = (op == 4'd9) ? word[11:8] : word[3:0];  // SW stores rd
        if (op == 4'd8 || op == 4'd9) begin
          imm = {{12{word[3]}}, word[3:0]};
        end else if (op >= 4'd10) begin
          imm = {8'h00, word[7:0]};
        end else begin
          imm = {12'h000, word[3:0]};
        end
        driveCycle(word, 1'b0, 4'd0, 16'd0);
        checkValue("srcReg1", 32'(id1), 32'(exBundle.srcReg1));
        checkValue("srcReg2", 32'(id2), 32'(exBundle.srcReg2));
        checkValue("aluIn1", 32'(regModel[id1]), 32'(exBundle.aluIn1));
        checkValue("aluIn2", 32'(imm), 32'(exBundle.aluIn2));
        checkValue("memWriteData", 32'(regModel[id2]), 32'(memBundle.memWriteData));
      end
    end
  end
endtask

task automatic controlTable();
  logic [15:0] word;
  for (int k = 0; k < 16; k++) begin
    word = {4'(k), 12'($urandom)};
    driveCycle(word, 1'b0, 4'd0, 16'd0);
    checkValue("control fields", 32'(expectedControl(4'(k))),
               32'({exBundle.aluOp, exBundle.zEn, exBundle.nvEn,
                    memBundle.memEnable, memBundle.memWrite, wbBundle.regWrite,
                    wbBundle.memToReg, wbBundle.hlt, wbBundle.pcs, isBranch}));
    checkValue("wbBundle.rd", 32'(word[11:8]), 32'(wbBundle.rd));
  end
endtask

task automatic branchDecision();
  logic [8:0]  imm;
  logic [15:0] pc;
  logic [15:0] target;
  logic [3:0]  rs;
  logic [2:0]  fl;
  for (int cnd = 0; cnd < 8; cnd++) begin
    for (int f = 0; f < 8; f++) begin
      imm    = 9'($urandom);
      pc     = 16'($urandom);
      target = pc + {{6{imm[8]}}, imm, 1'b0}; // Word offset to bytes
      driveBranch({4'd12, 3'(cnd), imm}, 3'(f), pc);
      checkValue("taken (B)", 32'(condHolds(3'(cnd), 3'(f))), 32'(taken));
      checkValue("branchTarget (B)", 32'(target), 32'(branchTarget));
      checkValue("isBranch (B)", 32'd1, 32'(isBranch));
    end
  end
  for (int n = 0; n < 16; n++) begin
    rs = 4'($urandom);
    fl = 3'($urandom);
    driveBranch({4'd13, 3'($urandom), 1'b0, rs, 4'd0}, fl, 16'($urandom));
    checkValue("taken (BR)", 32'(condHolds(instr[11:9], fl)), 32'(taken));
    checkValue("branchTarget (BR)", 32'(regModel[rs]), 32'(branchTarget));
  end
  for (int k = 0; k < 16; k++) begin
    if (k != 12 && k != 13) begin
      // Condition field set to unconditional, still never taken
      driveBranch({4'(k), 3'd7, 9'($urandom)}, 3'($urandom), 16'($urandom));
      checkValue("taken (non-branch)", 32'd0, 32'(taken));
      checkValue("isBranch (non-branch)", 32'd0, 32'(isBranch));
    end
  end
endtask

`endif

//--- test/decodeTb.sv
module decodeTb import cpuPkg::*; ();

  localparam int timeoutCycles = 2000; // Tests need about 250 cycles

  logic                 clk;
  logic                 rstN;
  logic [dataWidth-1:0] instr;
  logic [dataWidth-1:0] pcNext;
  flags_t               flags;
  regWrite_t            wbPort;
  exBundle_t            exBundle;
  memBundle_t           memBundle;
  wbBundle_t            wbBundle;
  logic                 isBranch;
  logic [dataWidth-1:0] branchTarget;
  logic                 taken;

  logic [dataWidth-1:0] regModel [regCount]; // Expected register contents, R0 stays zero
  int                   cycleCount = 0;

  `include "decodeTasks.svh"

  ////////////////////////////////////////////////////////////////////////////
  // DUT, clock and timeout
  ////////////////////////////////////////////////////////////////////////////
  decodeStage UUT (
    .clk, .rstN, .instr, .pcNext, .flags, .wbPort,
    .exBundle, .memBundle, .wbBundle,
    .isBranch, .branchTarget, .taken
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      failRun($sformatf("Timeout, tests still running after %0d cycles", timeoutCycles));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    rstN   = 1'b0;
    instr  = '0;
    pcNext = '0;
    flags  = '0;
    wbPort = '0;
    for (int i = 0; i < regCount; i++) begin
      regModel[i] = '0; // Reset clears the whole file
    end
    void'($urandom(32'hdf90_2233));

    repeat (3) @(posedge clk);
    rstN <= 1'b1;

    regWriteRead();
    r0AndBypass();
    immediateForms();
    controlTable();
    branchDecision();

    @(posedge clk);
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- all.f
+incdir+test
hw/cpuPkg.sv
hw/controlUnit.sv
hw/registerFile.sv
hw/branchControl.sv
hw/operandSelect.sv
hw/decodeStage.sv
test/decodeTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f all.f --top-module decodeTb -Mdir obj_dir

./obj_dir/VdecodeTb > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
